/* hw/compressed_decoder.sv */
/*
 * Compressed decoder
 * rebuilds the supported RVC forms as 32-bit encodings,
 * flags the rest, passes full-width instructions through
 */
`timescale 1ns/1ns
`default_nettype none

module compressed_decoder (
    input  wire logic [31:0] instr_i,
    output logic      [31:0] instr_o,
    output logic             illegal_o,
    output logic             is_compressed_o
);
    logic [15:0] c;      // compressed half
    logic [4:0]  rd_p;   // rd'/rs2' in [4:2] mapped to x8..x15
    logic [4:0]  rs1_p;  // rs1' in [9:7]

    assign c     = instr_i[15:0];
    assign rd_p  = {2'b01, c[4:2]};
    assign rs1_p = {2'b01, c[9:7]};
    assign is_compressed_o = (instr_i[1:0] != 2'b11);

    always_comb begin
        instr_o   = instr_i;  // full width and illegal forms pass unchanged
        illegal_o = 1'b0;
        if (is_compressed_o) begin
            illegal_o = 1'b1;  // cleared by every supported form
            unique case ({c[1:0], c[15:13]})
                // --------------------------------------------------
                // quadrant 0
                // --------------------------------------------------
                5'b00_010: begin  // c.lw -> lw rd', uimm(rs1')
                    instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010,
                                 rd_p, 7'b0000011};
                    illegal_o = 1'b0;
                end
                5'b00_110: begin  // c.sw -> sw rs2', uimm(rs1')
                    instr_o   = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010,
                                 c[11:10], c[6], 2'b00, 7'b0100011};
                    illegal_o = 1'b0;
                end
                // --------------------------------------------------
                // quadrant 1
                // --------------------------------------------------
                5'b01_000: begin  // c.addi -> addi rd, rd, imm
                    instr_o   = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], 7'b0010011};
                    illegal_o = 1'b0;
                end
                5'b01_010: begin  // c.li -> addi rd, x0, imm
                    instr_o   = {{7{c[12]}}, c[6:2], 5'b0, 3'b000, c[11:7], 7'b0010011};
                    illegal_o = 1'b0;
                end
                5'b01_101: begin  // c.j -> jal x0, offset
                    instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                 c[12], {8{c[12]}}, 5'b0, 7'b1101111};
                    illegal_o = 1'b0;
                end
                5'b01_110: begin  // c.beqz -> beq rs1', x0, offset
                    instr_o   = {{4{c[12]}}, c[6:5], c[2], 5'b0, rs1_p, 3'b000,
                                 c[11:10], c[4:3], c[12], 7'b1100011};
                    illegal_o = 1'b0;
                end
                // --------------------------------------------------
                // quadrant 2
                // --------------------------------------------------
                5'b10_100: begin
                    if (c[6:2] != 5'd0) begin  // rs2 = 0 is jr/jalr/ebreak
                        // c.add reads rd, c.mv reads x0
                        instr_o   = {7'b0, c[6:2], c[12] ? c[11:7] : 5'b0, 3'b000,
                                     c[11:7], 7'b0110011};
                        illegal_o = 1'b0;
                    end
                end
                default: ;  // unsupported, stays illegal
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/decode_consts.svh */
/*
 * Decode front sizing constants
 * shared by the buffers, the decode stage and the package
 */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define XLEN       32  // data and address width
`define FIFO_DEPTH 4   // entries per buffer, power of two
`define NR_ENTRIES 8   // transaction ids in flight, 3-bit tag

`endif

/* hw/decode_pkg.sv */
/*
 * Decode package
 * functional unit and operation encodings plus the fetch and
 * scoreboard entry layouts used along the decode front
 */
`default_nettype none

`include "decode_consts.svh"

package decode_pkg;

    typedef logic [$clog2(`NR_ENTRIES)-1:0] trans_id_t;  // rolling tag

    // --------------------------------------------------
    // functional units and operations
    // --------------------------------------------------
    typedef enum logic [2:0] {
        NONE, ALU, BRANCH, LOAD, STORE
    } fu_t;

    // narrow loads and stores fold into LW and SW, width lives in funct3
    typedef enum logic [4:0] {
        ADD, SUB, XOR, OR, AND, SLL, SRL, SRA, SLT, SLTU,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LW, SW
    } op_t;

    // --------------------------------------------------
    // entries
    // --------------------------------------------------
    typedef struct packed {
        logic [`XLEN-1:0] pc;           // address of the instruction
        logic [31:0]      instruction;  // raw bits, rvc in [15:0]
    } fetch_entry_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        trans_id_t        trans_id;
        fu_t              fu;
        op_t              op;
        logic [2:0]       funct3;         // access width for loads/stores
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [`XLEN-1:0] imm;            // sign-extended
        logic             is_compressed;
        logic             ex_valid;       // illegal instruction
        logic [19:0]      tval;           // low raw bits when ex_valid
    } scoreboard_entry_t;

endpackage

`default_nettype wire

/* hw/decode_top.sv */
/*
 * Decode front top
 * fetch buffer -> decode stage -> issue buffer, all valid/ready
 */
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module decode_top (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      flush_i,
    input  wire logic                      fetch_valid_i,
    output logic                           fetch_ready_o,
    input  wire decode_pkg::fetch_entry_t  fetch_entry_i,
    output logic                           issue_valid_o,
    input  wire logic                      issue_ready_i,
    output decode_pkg::scoreboard_entry_t  issue_entry_o
);
    import decode_pkg::*;

    logic              fb_valid, fb_ready;  // fetch buffer -> id stage
    fetch_entry_t      fb_entry;
    logic              id_valid, id_ready;  // id stage -> issue buffer
    scoreboard_entry_t id_entry;

    stream_fifo #(.payload_t(fetch_entry_t), .depth(`FIFO_DEPTH)) i_fetch_buffer (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (fetch_valid_i), .ready_o (fetch_ready_o), .data_i (fetch_entry_i),
        .valid_o (fb_valid),      .ready_i (fb_ready),      .data_o (fb_entry)
    );

    id_stage i_id_stage (
        .clk_i, .rst_ni, .flush_i,
        .fetch_valid_i (fb_valid), .fetch_ready_o (fb_ready), .fetch_entry_i (fb_entry),
        .issue_valid_o (id_valid), .issue_ready_i (id_ready), .issue_entry_o (id_entry)
    );

    stream_fifo #(.payload_t(scoreboard_entry_t), .depth(`FIFO_DEPTH)) i_issue_buffer (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (id_valid),      .ready_o (id_ready),      .data_i (id_entry),
        .valid_o (issue_valid_o), .ready_i (issue_ready_i), .data_o (issue_entry_o)
    );

endmodule

`default_nettype wire

/* hw/decoder.sv */
/*
 * Instruction decoder
 * maps an RV32I subset to a scoreboard entry with fu, op,
 * registers and sign-extended immediate; flags illegal encodings
 */
`timescale 1ns/1ns
`default_nettype none

module decoder (
    input  wire logic [31:0]              instr_i,
    input  wire logic [31:0]              pc_i,
    input  wire logic                     is_compressed_i,
    input  wire logic                     is_illegal_i,
    input  wire decode_pkg::trans_id_t    trans_id_i,
    output decode_pkg::scoreboard_entry_t entry_o
);
    import decode_pkg::*;

    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        illegal;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign f3 = instr_i[14:12];
    assign f7 = instr_i[31:25];

    // --------------------------------------------------
    // immediate formats
    // --------------------------------------------------
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        entry_o               = '0;  // unused fields read as zero
        entry_o.pc            = pc_i;
        entry_o.trans_id      = trans_id_i;
        entry_o.is_compressed = is_compressed_i;
        entry_o.fu            = NONE;
        entry_o.op            = ADD;
        illegal               = is_illegal_i;

        unique case (instr_i[6:0])
            7'b0110111: begin  // lui
                entry_o.fu = ALU;  entry_o.op = LUI;
                entry_o.rd = instr_i[11:7];  entry_o.imm = imm_u;
            end
            7'b0010111: begin  // auipc
                entry_o.fu = ALU;  entry_o.op = AUIPC;
                entry_o.rd = instr_i[11:7];  entry_o.imm = imm_u;
            end
            7'b1101111: begin  // jal
                entry_o.fu = BRANCH;  entry_o.op = JAL;
                entry_o.rd = instr_i[11:7];  entry_o.imm = imm_j;
            end
            7'b1100111: begin  // jalr, funct3 must be 0
                entry_o.fu  = BRANCH;  entry_o.op = JALR;
                entry_o.rd  = instr_i[11:7];  entry_o.rs1 = instr_i[19:15];
                entry_o.imm = imm_i;  entry_o.funct3 = f3;
                if (f3 != 3'b000) illegal = 1'b1;
            end
            7'b1100011: begin  // conditional branches
                entry_o.fu  = BRANCH;  entry_o.funct3 = f3;
                entry_o.rs1 = instr_i[19:15];  entry_o.rs2 = instr_i[24:20];
                entry_o.imm = imm_b;
                unique case (f3)
                    3'b000:  entry_o.op = BEQ;
                    3'b001:  entry_o.op = BNE;
                    3'b100:  entry_o.op = BLT;
                    3'b101:  entry_o.op = BGE;
                    3'b110:  entry_o.op = BLTU;
                    3'b111:  entry_o.op = BGEU;
                    default: illegal = 1'b1;  // 010, 011 unused
                endcase
            end
            7'b0000011: begin  // loads, width kept in funct3
                entry_o.fu  = LOAD;  entry_o.op = LW;  entry_o.funct3 = f3;
                entry_o.rd  = instr_i[11:7];  entry_o.rs1 = instr_i[19:15];
                entry_o.imm = imm_i;
                if (f3 == 3'b011 || f3[2:1] == 2'b11) illegal = 1'b1;
            end
            7'b0100011: begin  // stores
                entry_o.fu  = STORE;  entry_o.op = SW;  entry_o.funct3 = f3;
                entry_o.rs1 = instr_i[19:15];  entry_o.rs2 = instr_i[24:20];
                entry_o.imm = imm_s;
                if (f3[2] || f3 == 3'b011) illegal = 1'b1;
            end
            7'b0010011: begin  // op-imm, shifts keep the full I immediate
                entry_o.fu  = ALU;  entry_o.funct3 = f3;
                entry_o.rd  = instr_i[11:7];  entry_o.rs1 = instr_i[19:15];
                entry_o.imm = imm_i;
                unique case (f3)
                    3'b000: entry_o.op = ADD;
                    3'b010: entry_o.op = SLT;
                    3'b011: entry_o.op = SLTU;
                    3'b100: entry_o.op = XOR;
                    3'b110: entry_o.op = OR;
                    3'b111: entry_o.op = AND;
                    3'b001: begin
                        entry_o.op = SLL;
                        if (f7 != 7'b0) illegal = 1'b1;
                    end
                    3'b101: begin
                        entry_o.op = f7[5] ? SRA : SRL;
                        if ({f7[6], f7[4:0]} != 6'b0) illegal = 1'b1;
                    end
                endcase
            end
            7'b0110011: begin  // register-register
                entry_o.fu  = ALU;  entry_o.funct3 = f3;
                entry_o.rd  = instr_i[11:7];  entry_o.rs1 = instr_i[19:15];
                entry_o.rs2 = instr_i[24:20];
                unique case ({f7, f3})
                    10'b0000000_000: entry_o.op = ADD;
                    10'b0100000_000: entry_o.op = SUB;
                    10'b0000000_001: entry_o.op = SLL;
                    10'b0000000_010: entry_o.op = SLT;
                    10'b0000000_011: entry_o.op = SLTU;
                    10'b0000000_100: entry_o.op = XOR;
                    10'b0000000_101: entry_o.op = SRL;
                    10'b0100000_101: entry_o.op = SRA;
                    10'b0000000_110: entry_o.op = OR;
                    10'b0000000_111: entry_o.op = AND;
                    default:         illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        // illegal entries carry no operands, only the trap value
        if (illegal) begin
            entry_o.fu     = NONE;
            entry_o.op     = ADD;
            entry_o.funct3 = '0;
            entry_o.rd     = '0;
            entry_o.rs1    = '0;
            entry_o.rs2    = '0;
            entry_o.imm    = '0;
            entry_o.tval   = instr_i[19:0];  // raw bits, rvc passes through
        end
        entry_o.ex_valid = illegal;
    end

endmodule

`default_nettype wire

/* hw/id_stage.sv */
/*
 * Decode stage
 * expands and decodes one fetch entry into a registered scoreboard
 * entry, tags it with a rolling transaction id, clears on flush
 */
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module id_stage (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      flush_i,
    input  wire logic                      fetch_valid_i,
    output logic                           fetch_ready_o,
    input  wire decode_pkg::fetch_entry_t  fetch_entry_i,
    output logic                           issue_valid_o,
    input  wire logic                      issue_ready_i,
    output decode_pkg::scoreboard_entry_t  issue_entry_o
);
    import decode_pkg::*;

    logic              valid_q;
    scoreboard_entry_t entry_q, entry_dec;
    trans_id_t         trans_id_q;
    logic [31:0]       instr_exp;     // expanded instruction
    logic              illegal_c, is_comp;
    logic              accept;

    compressed_decoder i_compressed_decoder (
        .instr_i         (fetch_entry_i.instruction),
        .instr_o         (instr_exp),
        .illegal_o       (illegal_c),
        .is_compressed_o (is_comp)
    );

    decoder i_decoder (
        .instr_i         (instr_exp),
        .pc_i            (fetch_entry_i.pc),
        .is_compressed_i (is_comp),
        .is_illegal_i    (illegal_c),
        .trans_id_i      (trans_id_q),
        .entry_o         (entry_dec)
    );

    // --------------------------------------------------
    // pipeline register
    // --------------------------------------------------
    assign fetch_ready_o = !valid_q || issue_ready_i;  // empty or draining
    assign accept        = fetch_valid_i && fetch_ready_o && !flush_i;
    assign issue_valid_o = valid_q;
    assign issue_entry_o = entry_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= 1'b0;
            trans_id_q <= '0;
        end else if (flush_i) begin
            valid_q    <= 1'b0;
            trans_id_q <= '0;  // ids restart after flush
        end else begin
            if (accept)             valid_q <= 1'b1;
            else if (issue_ready_i) valid_q <= 1'b0;
            if (accept) begin
                trans_id_q <= (trans_id_q == trans_id_t'(`NR_ENTRIES - 1)) ?
                              '0 : trans_id_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) entry_q <= entry_dec;
    end

    // a stalled entry is neither dropped nor altered
    a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (issue_valid_o && !issue_ready_i && !flush_i) |=>
        (issue_valid_o && $stable(issue_entry_o)));

endmodule

`default_nettype wire

/* hw/stream_fifo.sv */
/*
 * Stream FIFO
 * valid/ready buffer with a type-parameter payload, fall-through
 * read from registered storage and a synchronous flush
 */
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module stream_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned depth     = `FIFO_DEPTH  // power of two, at least 2
) (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire logic     flush_i,
    input  wire logic     valid_i,
    output logic          ready_o,
    input  wire payload_t data_i,
    output logic          valid_o,
    input  wire logic     ready_i,
    output payload_t      data_o
);
    localparam int unsigned ptr_w = $clog2(depth);
    localparam int unsigned cnt_w = $clog2(depth + 1);

    payload_t           mem_q [depth];  // storage, no reset needed
    logic [ptr_w-1:0]   wr_ptr_q, rd_ptr_q;
    logic [cnt_w-1:0]   count_q;
    logic               full, push, pop;

    assign full    = (count_q == cnt_w'(depth));
    assign ready_o = !full || ready_i;      // full still takes a push on pop
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];       // first word falls through

    assign push = valid_i && ready_o && !flush_i;
    assign pop  = valid_o && ready_i && !flush_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin  // drop everything pending
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // natural wrap
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr_q] <= data_i;
    end

    // an overflow or an underflow would carry the count out of 0..depth
    a_count_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= cnt_w'(depth));
    // both pointers move together with the count
    a_ptr_match : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ptr_w'(wr_ptr_q - rd_ptr_q) == count_q[ptr_w-1:0]);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the decode front testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f vlog.f --top-module tb_decode -o tb_decode
./obj_dir/tb_decode | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi

/* test/decode_trace.txt */
# I pc instr | E fu op funct3 rd rs1 rs2 imm is_compressed ex_valid tval | F flush
# all fields hex, fu and op as decode_pkg enum encodings
I 00001000 123452b7
E 1 a 0 05 00 00 12345000 0 0 00000
I 00001004 008000ef
E 2 c 0 01 00 00 00000008 0 0 00000
I 00001008 00008067
E 2 d 0 00 01 00 00000000 0 0 00000
I 0000100c feb51ee3
E 2 f 1 00 0a 0b fffffffc 0 0 00000
I 00001010 01012603
E 3 14 2 0c 02 00 00000010 0 0 00000
I 00001014 fff14683
E 3 14 4 0d 02 00 ffffffff 0 0 00000
I 00001018 00e12423
E 4 15 2 00 02 0e 00000008 0 0 00000
I 0000101c 4037d793
E 1 7 5 0f 0f 00 00000403 0 0 00000
I 00001020 405201b3
E 1 1 0 03 04 05 00000000 0 0 00000
I 00001024 0000147d
E 1 0 0 08 08 00 ffffffff 1 0 00000
I 00001026 00004495
E 1 0 0 09 00 00 00000005 1 0 00000
I 00001028 0000952e
E 1 0 0 0a 0a 0b 00000000 1 0 00000
I 0000102a 00004144
E 3 14 2 09 0a 00 00000004 1 0 00000
I 0000102c 0000c60c
E 4 15 2 00 0c 0b 00000008 1 0 00000
I 0000102e 0000a009
E 2 c 0 00 00 00 00000002 1 0 00000
I 00001030 0000c401
E 2 e 0 00 08 00 00000008 1 0 00000
I 00001032 ffffffff
E 0 0 0 00 00 00 00000000 0 1 fffff
I 00001036 12340000
E 0 0 0 00 00 00 00000000 1 1 40000
I 00002000 00000013
I 00002004 00000013
I 00002008 00000013
I 0000200c 00000013
I 00002010 00000013
I 00002014 00000013
I 00002018 00000013
I 0000201c 00000013
I 00002020 00000013
F
I 00003000 00004495
E 1 0 0 09 00 00 00000005 1 0 00000

/* test/tb_decode.sv */
/*
 * Decode front testbench
 * trace-driven stimulus with random issue back-pressure, a fill
 * phase, flush checks and field-by-field entry compares
 */
`timescale 1ns/1ns
`default_nettype none

module tb_decode;
    import decode_pkg::*;

    localparam int TIMEOUT = 200;  // cycles per wait

    logic              clk_i, rst_ni, flush_i;
    logic              fetch_valid_i, fetch_ready_o;
    fetch_entry_t      fetch_entry_i;
    logic              issue_valid_o, issue_ready_i;
    scoreboard_entry_t issue_entry_o;

    scoreboard_entry_t exp_q [$];  // expected, in input order
    scoreboard_entry_t got_q [$];  // taken from the issue port
    int                value_errors, other_errors;
    logic              hold_ready;  // forces issue_ready_i low
    trans_id_t         next_id;     // id of the next accepted input
    byte               kind [256];
    logic [31:0]       fld [256][10];
    int                n_lines;

    decode_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // random ready, sampled by the DUT at the next edge
    initial begin
        void'($urandom(32'hd7c0_5bae));
        forever begin
            @(posedge clk_i);
            #1 issue_ready_i = hold_ready ? 1'b0 : 1'($urandom_range(0, 1));
        end
    end

    // monitor, a transfer completes at the following rising edge
    always @(negedge clk_i) begin
        if (rst_ni && !flush_i && issue_valid_o && issue_ready_i) got_q.push_back(issue_entry_o);
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic field_diff(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_entry(input scoreboard_entry_t got, input scoreboard_entry_t exp);
        field_diff("pc", got.pc, exp.pc);
        field_diff("trans_id", 32'(got.trans_id), 32'(exp.trans_id));
        field_diff("fu", 32'(got.fu), 32'(exp.fu));
        field_diff("op", 32'(got.op), 32'(exp.op));
        field_diff("funct3", 32'(got.funct3), 32'(exp.funct3));
        field_diff("rd", 32'(got.rd), 32'(exp.rd));
        field_diff("rs1", 32'(got.rs1), 32'(exp.rs1));
        field_diff("rs2", 32'(got.rs2), 32'(exp.rs2));
        field_diff("imm", got.imm, exp.imm);
        field_diff("is_compressed", 32'(got.is_compressed), 32'(exp.is_compressed));
        field_diff("ex_valid", 32'(got.ex_valid), 32'(exp.ex_valid));
        field_diff("tval", 32'(got.tval), 32'(exp.tval));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // --------------------------------------------------
    // stimulus, every task starts and ends 1 ns after an edge
    // --------------------------------------------------
    task automatic drive_input(input logic [31:0] pc, input logic [31:0] instr);
        int cycles;
        cycles = 0;
        fetch_valid_i = 1'b1;
        fetch_entry_i = '{pc: pc, instruction: instr};
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!fetch_ready_o && cycles < TIMEOUT);
        if (!fetch_ready_o) begin
            $display("timeout: fetch port never accepted the entry at pc %h", pc);
            other_errors++;
        end else begin
            next_id++;  // wraps at 8 with the 3-bit tag
        end
        @(posedge clk_i);
        #1 fetch_valid_i = 1'b0;
    endtask

    task automatic drain_and_compare();
        int cycles;
        cycles = 0;
        while (got_q.size() < exp_q.size() && cycles < TIMEOUT) begin
            @(posedge clk_i);
            #1 cycles++;
        end
        repeat (5) @(posedge clk_i);  // catch duplicates
        #1;
        if (got_q.size() != exp_q.size()) begin
            $display("got %0d entries from the issue port, expected %0d",
                     got_q.size(), exp_q.size());
            other_errors++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) check_entry(got_q[i], exp_q[i]);
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic flush_pipeline();
        int cycles;
        cycles = 0;
        while (fetch_ready_o && cycles < TIMEOUT) begin  // fill phase
            @(posedge clk_i);
            #1 cycles++;
        end
        check_bit("fetch_ready_o when full", fetch_ready_o, 1'b0);
        flush_i = 1'b1;
        @(posedge clk_i);
        #1 flush_i = 1'b0;
        next_id = '0;
        check_bit("issue_valid_o after flush", issue_valid_o, 1'b0);
        check_bit("fetch_ready_o after flush", fetch_ready_o, 1'b1);
        hold_ready = 1'b0;
        drain_and_compare();  // nothing pending may come out
    endtask

    task automatic read_trace();
        int          fd;
        string       line;
        logic [31:0] v [10];
        n_lines = 0;
        fd = $fopen("test/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
            kind[n_lines] = line[0];
            if (line[0] == "I") void'($sscanf(line, "I %h %h", v[0], v[1]));
            if (line[0] == "E") begin
                void'($sscanf(line, "E %h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]));
            end
            fld[n_lines] = v;
            n_lines++;
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        scoreboard_entry_t e;
        logic [31:0]       last_pc;
        trans_id_t         last_id;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_entry_i = '0;
        issue_ready_i = 1'b0;
        hold_ready = 1'b0;
        next_id = '0;
        value_errors = 0;
        other_errors = 0;
        last_pc = '0;
        last_id = '0;
        read_trace();
        repeat (3) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        check_bit("fetch_ready_o after reset", fetch_ready_o, 1'b1);
        check_bit("issue_valid_o after reset", issue_valid_o, 1'b0);

        for (int i = 0; i < n_lines; i++) begin
            if (kind[i] == "I") begin
                // an input with no expected entry stays pending until a flush
                if (!hold_ready && (i + 1 >= n_lines || kind[i+1] != "E")) begin
                    drain_and_compare();
                    hold_ready = 1'b1;
                    @(posedge clk_i);
                    #1;
                end
                last_pc = fld[i][0];
                last_id = next_id;
                drive_input(fld[i][0], fld[i][1]);
            end else if (kind[i] == "E") begin
                e               = '0;
                e.pc            = last_pc;
                e.trans_id      = last_id;
                e.fu            = fu_t'(fld[i][0][2:0]);
                e.op            = op_t'(fld[i][1][4:0]);
                e.funct3        = fld[i][2][2:0];
                e.rd            = fld[i][3][4:0];
                e.rs1           = fld[i][4][4:0];
                e.rs2           = fld[i][5][4:0];
                e.imm           = fld[i][6];
                e.is_compressed = fld[i][7][0];
                e.ex_valid      = fld[i][8][0];
                e.tval          = fld[i][9][19:0];
                exp_q.push_back(e);
            end else if (kind[i] == "F") begin
                flush_pipeline();
            end
        end
        drain_and_compare();

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/decode_pkg.sv
hw/stream_fifo.sv
hw/compressed_decoder.sv
hw/decoder.sv
hw/id_stage.sv
hw/decode_top.sv
test/tb_decode.sv
